// File: logic/cmd_pkg.sv
package cmd_pkg;

  // Header byte codes, top byte of a header word
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_CLK_DIVISOR      = 8'h0b,
    CMD_API_VERSION      = 8'hfe
  } cmd_e;

  // Reply bytes for CMD_API_VERSION
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd0;
  localparam logic [7:0] VERSION_PATCH = 8'd2;

  typedef struct packed {
    logic [7:0]  header;   // Holds a cmd_e code
    logic [55:0] payload;
  } hdr_view_t;

  typedef struct packed {
    logic [31:0] unused;
    logic [31:0] value;    // Duration or increment word
  } data_view_t;

  // One SPI word, read as header or as data by message state
  typedef union packed {
    hdr_view_t  hdr;
    data_view_t data;
  } spi_word_u;

endpackage

// File: logic/motion_pkg.sv
package motion_pkg;

  localparam int ENC_BITS = 32;  // Encoder count width
  localparam int DUR_BITS = 32;
  localparam int INC_BITS = 32;

  // Headroom above the increment so long negative runs do not wrap
  localparam int ACC_BITS = 48;

  // Accumulator level worth one step
  localparam int STEP_THRESHOLD = 32'sd1 << 30;

  // One queued move segment
  typedef struct packed {
    logic                       dir;
    logic [DUR_BITS-1:0]        duration;   // Ticks
    logic signed [INC_BITS-1:0] increment;
    logic signed [INC_BITS-1:0] inc_inc;    // Added to increment every tick
  } segment_t;

endpackage

// File: logic/move_if.sv
`timescale 1ns/100ps

// Segment transfer, moves when valid and accept are both high
interface move_if;
  logic                  valid;
  logic                  accept;
  motion_pkg::segment_t  seg;

  // Command decoder side
  modport writer (output valid, output seg, input accept);

  // Queue write port, accept means not full
  modport queue_in (input valid, input seg, output accept);

  // Queue read port, valid means not empty
  modport queue_out (output valid, output seg, input accept);

  // Step generator side, accept while loading
  modport reader (input valid, input seg, output accept);

endinterface

// File: logic/spi_word_rx.sv
`timescale 1ns/100ps

module spi_word_rx (
  input  logic                CLK,
  input  logic                resetn,
  input  logic                sck,
  input  logic                cs,
  input  logic                copi,
  output logic                cipo,
  input  cmd_pkg::spi_word_u  tx_word,
  output cmd_pkg::spi_word_u  rx_word,
  output logic                word_valid
);

  logic [2:0]  sck_s;   // Two sync stages plus history
  logic [2:0]  cs_s;
  logic [1:0]  copi_s;
  logic [63:0] shift_r;
  logic [5:0]  bit_cnt;
  logic        cipo_r;
  logic        valid_r;
  logic        sck_rise, sck_fall, cs_fall, cs_low;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_s  <= '0;
      cs_s   <= '1;
      copi_s <= '0;
    end else begin
      sck_s  <= {sck_s[1:0], sck};
      cs_s   <= {cs_s[1:0], cs};
      copi_s <= {copi_s[0], copi};
    end
  end

  assign sck_rise = sck_s[1] & ~sck_s[2];
  assign sck_fall = ~sck_s[1] & sck_s[2];
  assign cs_fall  = ~cs_s[1] & cs_s[2];
  assign cs_low   = ~cs_s[1];

  // Mode 0, COPI sampled on rise and CIPO updated on fall
  always_ff @(posedge CLK) begin
    if (cs_fall)
      shift_r <= tx_word;  // Reply to the previous word
    else if (cs_low && sck_rise)
      shift_r <= {shift_r[62:0], copi_s[1]};
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt <= '0;
      cipo_r  <= 1'b0;
      valid_r <= 1'b0;
    end else begin
      valid_r <= 1'b0;
      if (cs_fall) begin
        bit_cnt <= '0;
        cipo_r  <= tx_word[63];
      end else if (!cs_low) begin
        bit_cnt <= '0;  // Partial word dropped
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 6'd1;
        if (bit_cnt == 6'd63)
          valid_r <= 1'b1;
      end else if (sck_fall) begin
        cipo_r <= shift_r[63];
      end
    end
  end

  assign cipo       = cipo_r;
  assign rx_word    = shift_r;
  assign word_valid = valid_r;

endmodule

// File: logic/cmd_decoder.sv
`timescale 1ns/100ps

module cmd_decoder #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic                                 CLK,
  input  logic                                 resetn,
  input  cmd_pkg::spi_word_u                   rx_word,
  input  logic                                 word_valid,
  input  logic                                 halt,       // Active low
  input  logic signed [motion_pkg::ENC_BITS-1:0] enc_count,
  move_if.writer                               mv,
  output cmd_pkg::spi_word_u                   tx_word,
  output logic                                 enable,
  output logic [7:0]                           tick_div
);

  // Queue pointer logic depends on a power of two depth
  if (MOVE_DEPTH < 2 || (MOVE_DEPTH & (MOVE_DEPTH - 1)) != 0) begin : g_depth_check
    $error("MOVE_DEPTH must be a power of two of at least 2");
  end

  logic [1:0]                            msg_cnt;  // 0 header, 1..3 move data words
  logic                                  wr_valid;
  logic                                  is_move_hdr;
  motion_pkg::segment_t                  seg_r;
  logic signed [motion_pkg::ENC_BITS-1:0] enc_snap;

  assign is_move_hdr = word_valid && (msg_cnt == 2'd0) &&
                       (rx_word.hdr.header == cmd_pkg::CMD_COORDINATED_STEP);

  // Segment fields collected across the move message
  always_ff @(posedge CLK) begin
    if (is_move_hdr) begin
      seg_r.dir <= rx_word.hdr.payload[0];
      enc_snap  <= enc_count;  // Position at move start
    end
    if (word_valid) begin
      case (msg_cnt)
        2'd1: seg_r.duration  <= rx_word.data.value;
        2'd2: seg_r.increment <= rx_word.data.value;
        2'd3: seg_r.inc_inc   <= rx_word.data.value;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      msg_cnt  <= 2'd0;
      wr_valid <= 1'b0;
      tx_word  <= '0;
      enable   <= 1'b0;
      tick_div <= 8'd3;
    end else begin
      wr_valid <= 1'b0;
      if (word_valid) begin
        tx_word <= '0;
        if (msg_cnt == 2'd0) begin
          case (rx_word.hdr.header)
            cmd_pkg::CMD_COORDINATED_STEP: msg_cnt <= 2'd1;
            cmd_pkg::CMD_MOTOR_ENABLE:     enable <= rx_word.hdr.payload[0];
            cmd_pkg::CMD_CLK_DIVISOR:      tick_div <= rx_word.hdr.payload[7:0];
            cmd_pkg::CMD_API_VERSION:
              tx_word <= {40'd0, cmd_pkg::VERSION_MAJOR,
                          cmd_pkg::VERSION_MINOR, cmd_pkg::VERSION_PATCH};
            default: ;
          endcase
        end else begin
          msg_cnt <= msg_cnt + 2'd1;  // Wraps to header after word 3
          if (msg_cnt == 2'd2)
            tx_word <= 64'(enc_snap);
          if (msg_cnt == 2'd3)
            wr_valid <= halt;  // No new segment while halted
        end
      end
    end
  end

  // Dropped if the queue is full on this pulse
  assign mv.valid = wr_valid;
  assign mv.seg   = seg_r;

endmodule

// File: logic/move_queue.sv
`timescale 1ns/100ps

module move_queue #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic     CLK,
  input  logic     resetn,
  input  logic     halt,   // Active low, flushes
  move_if.queue_in  wr,
  move_if.queue_out rd,
  output logic     queue_space
);

  localparam int IDX_BITS = $clog2(MOVE_DEPTH);

  motion_pkg::segment_t mem [MOVE_DEPTH];

  // Extra top bit tells full from empty
  logic [IDX_BITS:0] wr_ptr;
  logic [IDX_BITS:0] rd_ptr;
  logic              full, empty;
  logic              wr_en, rd_en;

  assign full  = (wr_ptr[IDX_BITS] != rd_ptr[IDX_BITS]) &&
                 (wr_ptr[IDX_BITS-1:0] == rd_ptr[IDX_BITS-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  assign wr_en = wr.valid && !full && halt;
  assign rd_en = rd.valid && rd.accept;

  always_ff @(posedge CLK) begin
    if (wr_en)
      mem[wr_ptr[IDX_BITS-1:0]] <= wr.seg;
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (!halt)
        rd_ptr <= wr_ptr;  // Drop everything queued
      else if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign wr.accept   = !full;
  assign rd.valid    = !empty;
  assign rd.seg      = mem[rd_ptr[IDX_BITS-1:0]];  // Head visible the cycle after write
  assign queue_space = !full;

endmodule

// File: logic/dda_stepper.sv
`timescale 1ns/100ps

module dda_stepper (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       halt,      // Active low, aborts the segment
  input  logic [7:0] tick_div,
  move_if.reader     mv,
  output logic       step,
  output logic       dir,
  output logic       move_done
);

  localparam int AW = motion_pkg::ACC_BITS;
  localparam int IW = motion_pkg::INC_BITS;
  localparam logic signed [AW-1:0] THRESH = AW'(motion_pkg::STEP_THRESHOLD);

  logic                             busy;
  logic [motion_pkg::DUR_BITS-1:0]  tick_cnt;  // Ticks left in the segment
  logic [7:0]                       div_cnt;
  logic signed [IW-1:0]             inc_r;
  logic signed [IW-1:0]             inc_inc_r;
  logic signed [AW-1:0]             acc;
  logic signed [AW-1:0]             acc_add, acc_sub;
  logic                             step_r, dir_r, done_r;
  logic                             tick, take_step, load;

  assign load      = mv.valid && mv.accept;
  assign tick      = busy && (div_cnt == 8'd0) && (tick_cnt != '0);
  assign take_step = (acc >= THRESH) && !step_r;  // At most one pulse per two cycles
  assign acc_add   = tick ? AW'(inc_r) : '0;
  assign acc_sub   = take_step ? THRESH : '0;

  always_ff @(posedge CLK) begin
    if (!resetn || !halt) begin
      busy   <= 1'b0;
      acc    <= '0;
      step_r <= 1'b0;
      if (!resetn) begin
        dir_r  <= 1'b0;
        done_r <= 1'b0;
      end
    end else begin
      acc    <= acc + acc_add - acc_sub;  // Remainder carries to next segment
      step_r <= take_step;
      if (load) begin
        busy  <= 1'b1;
        dir_r <= mv.seg.dir;
      end else if (busy && tick_cnt == '0) begin
        busy   <= 1'b0;
        done_r <= ~done_r;
      end
    end
  end

  // Segment datapath
  always_ff @(posedge CLK) begin
    if (load) begin
      tick_cnt  <= mv.seg.duration;
      div_cnt   <= tick_div;
      inc_r     <= mv.seg.increment;
      inc_inc_r <= mv.seg.inc_inc;
    end else if (tick) begin
      tick_cnt <= tick_cnt - 1'b1;
      div_cnt  <= tick_div;
      inc_r    <= inc_r + inc_inc_r;
    end else if (div_cnt != 8'd0) begin
      div_cnt <= div_cnt - 8'd1;
    end
  end

  assign mv.accept = !busy && halt;
  assign step      = step_r;
  assign dir       = dir_r;
  assign move_done = done_r;

endmodule

// File: logic/quad_enc.sv
`timescale 1ns/100ps

module quad_enc (
  input  logic                                  CLK,
  input  logic                                  resetn,
  input  logic                                  a,
  input  logic                                  b,
  output logic signed [motion_pkg::ENC_BITS-1:0] count,
  output logic                                  fault
);

  localparam int EW = motion_pkg::ENC_BITS;

  logic [2:0] a_s;  // Stage 2 is the previous sample
  logic [2:0] b_s;
  logic       a_edge, b_edge, count_up;

  always_ff @(posedge CLK) begin
    a_s <= {a_s[1:0], a};
    b_s <= {b_s[1:0], b};
  end

  assign a_edge   = a_s[1] ^ a_s[2];
  assign b_edge   = b_s[1] ^ b_s[2];
  assign count_up = a_s[1] ^ b_s[2];  // High when A leads B

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count <= '0;
      fault <= 1'b0;
    end else if (a_edge && b_edge) begin
      fault <= 1'b1;  // Both moved at once, sticky
    end else if (a_edge || b_edge) begin
      count <= count_up ? count + EW'(1) : count - EW'(1);
    end
  end

endmodule

// File: logic/stepper_top.sv
`timescale 1ns/100ps

module stepper_top #(
  parameter int MOVE_DEPTH = 4
) (
  input  logic CLK,
  input  logic resetn,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  output logic CIPO,
  input  logic ENC_A,
  input  logic ENC_B,
  input  logic HALT,        // Active low
  output logic STEP,
  output logic DIR,
  output logic ENABLE,
  output logic MOVE_DONE,
  output logic BUFFER_DTR,
  output logic ENC_FAULT
);

  cmd_pkg::spi_word_u                    rx_word;
  cmd_pkg::spi_word_u                    tx_word;
  logic                                  word_valid;
  logic signed [motion_pkg::ENC_BITS-1:0] enc_count;
  logic [7:0]                            tick_div;

  move_if wr_move ();  // Decoder to queue
  move_if rd_move ();  // Queue to step generator

  spi_word_rx u_spi (
    .CLK        (CLK),
    .resetn     (resetn),
    .sck        (SCK),
    .cs         (CS),
    .copi       (COPI),
    .cipo       (CIPO),
    .tx_word    (tx_word),
    .rx_word    (rx_word),
    .word_valid (word_valid)
  );

  cmd_decoder #(.MOVE_DEPTH(MOVE_DEPTH)) u_dec (
    .CLK        (CLK),
    .resetn     (resetn),
    .rx_word    (rx_word),
    .word_valid (word_valid),
    .halt       (HALT),
    .enc_count  (enc_count),
    .mv         (wr_move.writer),
    .tx_word    (tx_word),
    .enable     (ENABLE),
    .tick_div   (tick_div)
  );

  move_queue #(.MOVE_DEPTH(MOVE_DEPTH)) u_queue (
    .CLK         (CLK),
    .resetn      (resetn),
    .halt        (HALT),
    .wr          (wr_move.queue_in),
    .rd          (rd_move.queue_out),
    .queue_space (BUFFER_DTR)
  );

  dda_stepper u_dda (
    .CLK       (CLK),
    .resetn    (resetn),
    .halt      (HALT),
    .tick_div  (tick_div),
    .mv        (rd_move.reader),
    .step      (STEP),
    .dir       (DIR),
    .move_done (MOVE_DONE)
  );

  quad_enc u_enc (
    .CLK    (CLK),
    .resetn (resetn),
    .a      (ENC_A),
    .b      (ENC_B),
    .count  (enc_count),
    .fault  (ENC_FAULT)
  );

endmodule

// File: sim/stepper_top_properties.sv
`timescale 1ns/100ps

module stepper_top_properties (
  input logic CLK,
  input logic resetn,
  input logic STEP,
  input logic ENABLE,
  input logic BUFFER_DTR,
  input logic HALT,
  input logic wr_valid,
  input logic rd_valid,
  input logic rd_accept
);

  int assert_fails = 0;  // Summed into the closing count

  // Single cycle step pulses
  step_single: assert property (@(posedge CLK) disable iff (!resetn) STEP |=> !STEP)
    else begin
      assert_fails++;
      $error("STEP high for two cycles in a row");
    end

  // A write pulse into a full queue must leave it full
  no_write_when_full: assert property (@(posedge CLK) disable iff (!resetn)
                                       wr_valid && !BUFFER_DTR && HALT &&
                                       !(rd_valid && rd_accept) |=> !BUFFER_DTR)
    else begin
      assert_fails++;
      $error("Queue took a write while BUFFER_DTR low");
    end

  quiet_after_reset: assert property (@(posedge CLK) $rose(resetn) |-> !ENABLE && !STEP)
    else begin
      assert_fails++;
      $error("ENABLE or STEP high right after reset release");
    end

endmodule

bind stepper_top stepper_top_properties u_props (
  .CLK        (CLK),
  .resetn     (resetn),
  .STEP       (STEP),
  .ENABLE     (ENABLE),
  .BUFFER_DTR (BUFFER_DTR),
  .HALT       (HALT),
  .wr_valid   (wr_move.valid),
  .rd_valid   (rd_move.valid),
  .rd_accept  (rd_move.accept)
);

// File: sim/tb_stepper_top.sv
`timescale 1ns/100ps

module tb_stepper_top;

  localparam int MOVE_DEPTH = 4;
  localparam int SCK_HALF   = 4;    // CLK cycles per SCK half period
  localparam int CS_GAP     = 6;
  localparam int WORD_CYC   = 64 * 2 * SCK_HALF + SCK_HALF + CS_GAP;
  localparam int MSG_CYC    = 4 * WORD_CYC;
  localparam int SLOW_DIV   = 200;
  // First queued move must outlast the sends that fill the queue and overflow it
  localparam int LONG_TICKS = ((MOVE_DEPTH + 1) * MSG_CYC) / (SLOW_DIV + 1) + 8;
  localparam int HALT_TICKS = 40;
  localparam int QUIET_CYC  = 3000;
  localparam int DROP_WAIT_CYC = 6 * (SLOW_DIV + 1);
  localparam int SPI_WORDS  = 64;   // Upper bound on words sent by all tests
  localparam int FAST_TICKS = 64 + 16 + 8 + 32;
  localparam int SLOW_TICKS = LONG_TICKS + 4 * MOVE_DEPTH + HALT_TICKS;
  localparam int TIMEOUT_CYC = SPI_WORDS * WORD_CYC + FAST_TICKS * 4 +
                               SLOW_TICKS * (SLOW_DIV + 1) + QUIET_CYC + DROP_WAIT_CYC;
  localparam longint THRESH = motion_pkg::STEP_THRESHOLD;
  localparam int QUARTER = motion_pkg::STEP_THRESHOLD / 4;
  localparam int EIGHTH  = motion_pkg::STEP_THRESHOLD / 8;

  logic CLK = 1'b0;
  logic resetn, SCK, CS, COPI, ENC_A, ENC_B, HALT;
  logic CIPO, STEP, DIR, ENABLE, MOVE_DONE, BUFFER_DTR, ENC_FAULT;

  int     errors = 0;
  int     cyc = 0;
  int     step_count = 0;
  int     done_count = 0;
  int     load_cycle = 0;
  int     done_cycle = 0;
  logic   done_prev = 1'b0;
  longint model_acc = 0;     // Reference DDA accumulator
  int     enc_state = 0;
  int     enc_expect = 0;

  stepper_top #(.MOVE_DEPTH(MOVE_DEPTH)) DUT (
    .CLK(CLK), .resetn(resetn), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .ENC_A(ENC_A), .ENC_B(ENC_B), .HALT(HALT), .STEP(STEP), .DIR(DIR),
    .ENABLE(ENABLE), .MOVE_DONE(MOVE_DONE), .BUFFER_DTR(BUFFER_DTR), .ENC_FAULT(ENC_FAULT)
  );

  always #4 CLK = ~CLK;

  // Step pulses, done toggles and segment loads
  always @(posedge CLK) begin
    cyc <= cyc + 1;
    if (resetn) begin
      if (STEP)
        step_count <= step_count + 1;
      if (MOVE_DONE != done_prev) begin
        done_count <= done_count + 1;
        done_cycle <= cyc;
      end
      if (DUT.rd_move.valid && DUT.rd_move.accept)
        load_cycle <= cyc;
    end
    done_prev <= MOVE_DONE;
  end

  initial begin : watchdog
    while (cyc < TIMEOUT_CYC)
      @(posedge CLK);
    $display("Timeout after %0d cycles, a test stopped making progress", TIMEOUT_CYC);
    $display("Simulation failed");
    $finish;
  end

  task wait_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task check_word(input string name, input cmd_pkg::spi_word_u got,
                  input cmd_pkg::spi_word_u exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task check_count(input string name, input logic signed [motion_pkg::ENC_BITS-1:0] got,
                   input logic signed [motion_pkg::ENC_BITS-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Mode 0 host, one 64-bit word, MSB first
  task spi_xfer(input cmd_pkg::spi_word_u tx, output cmd_pkg::spi_word_u rx);
    logic [63:0] tx_bits;
    logic [63:0] rx_bits;
    int          i;
    tx_bits = tx;
    CS = 1'b0;
    for (i = 63; i >= 0; i--) begin
      COPI = tx_bits[i];
      wait_cycles(SCK_HALF);
      rx_bits[i] = CIPO;  // Settled since the last falling edge
      SCK = 1'b1;
      wait_cycles(SCK_HALF);
      SCK = 1'b0;
    end
    wait_cycles(SCK_HALF);
    CS = 1'b1;
    wait_cycles(CS_GAP);
    rx = rx_bits;
  endtask

  task set_tick_div(input int div);
    cmd_pkg::spi_word_u reply;
    spi_xfer({cmd_pkg::CMD_CLK_DIVISOR, 48'd0, 8'(div)}, reply);
  endtask

  task send_move(input logic dir, input int dur, input int inc, input int inc_inc,
                 output cmd_pkg::spi_word_u reply);
    spi_xfer({cmd_pkg::CMD_COORDINATED_STEP, 55'd0, dir}, reply);
    spi_xfer({32'd0, dur}, reply);
    spi_xfer({32'd0, inc}, reply);
    spi_xfer({32'd0, inc_inc}, reply);  // Reply carries the header snapshot
  endtask

  // Accumulate per tick, one threshold off per step
  task dda_model(input int dur, input int inc, input int inc_inc, output int steps);
    longint inc_l;
    int     t;
    inc_l = inc;
    steps = 0;
    for (t = 0; t < dur; t++) begin
      model_acc += inc_l;
      inc_l += inc_inc;
      while (model_acc >= THRESH) begin
        model_acc -= THRESH;
        steps++;
      end
    end
  endtask

  task wait_toggles(input int target);
    while (done_count < target)
      wait_cycles(1);
    wait_cycles(4);  // Last step can land with the toggle
  endtask

  task run_move(input logic dir, input int dur, input int inc, input int inc_inc,
                output cmd_pkg::spi_word_u reply);
    int base_steps;
    int base_done;
    int exp_steps;
    base_steps = step_count;
    base_done  = done_count;
    dda_model(dur, inc, inc_inc, exp_steps);
    send_move(dir, dur, inc, inc_inc, reply);
    wait_toggles(base_done + 1);
    check_count("step_count", step_count - base_steps, exp_steps);
    check_count("move_done_toggles", done_count - base_done, 1);
    check_bit("DIR", DIR, dir);
  endtask

  // One quadrature edge along 00, 10, 11, 01
  task quad_move(input logic forward);
    enc_state = forward ? (enc_state + 1) % 4 : (enc_state + 3) % 4;
    case (enc_state)
      0: {ENC_A, ENC_B} = 2'b00;
      1: {ENC_A, ENC_B} = 2'b10;
      2: {ENC_A, ENC_B} = 2'b11;
      default: {ENC_A, ENC_B} = 2'b01;
    endcase
    enc_expect += forward ? 1 : -1;
    wait_cycles(4);
  endtask

  task check_reset_state();
    check_bit("STEP", STEP, 1'b0);
    check_bit("ENABLE", ENABLE, 1'b0);
    check_bit("MOVE_DONE", MOVE_DONE, 1'b0);
    check_bit("CIPO", CIPO, 1'b0);
    check_bit("BUFFER_DTR", BUFFER_DTR, 1'b1);
  endtask

  task test_version_enable();
    cmd_pkg::spi_word_u reply;
    spi_xfer({cmd_pkg::CMD_API_VERSION, 56'd0}, reply);
    spi_xfer(64'd0, reply);
    check_word("version reply", reply, {40'd0, cmd_pkg::VERSION_MAJOR,
                                        cmd_pkg::VERSION_MINOR, cmd_pkg::VERSION_PATCH});
    spi_xfer({cmd_pkg::CMD_MOTOR_ENABLE, 55'd0, 1'b1}, reply);
    check_word("reply to plain word", reply, 64'd0);
    check_bit("ENABLE", ENABLE, 1'b1);
    spi_xfer({cmd_pkg::CMD_MOTOR_ENABLE, 56'd0}, reply);
    check_bit("ENABLE", ENABLE, 1'b0);
  endtask

  task test_constant_move();
    cmd_pkg::spi_word_u reply;
    int span;
    set_tick_div(3);
    run_move(1'b1, 64, QUARTER, 0, reply);
    span = done_cycle - load_cycle;
    if (span < 64 * 4 - 4 || span > 64 * 4 + 4) begin
      $display("[FAIL] %0t ns move_cycles: got %0d, expected %0d +/- 4", $time, span, 64 * 4);
      errors++;
    end
  endtask

  // Increment ramps from zero
  task test_accel_move();
    cmd_pkg::spi_word_u reply;
    run_move(1'b0, 16, 0, motion_pkg::STEP_THRESHOLD / 32, reply);
  endtask

  task test_encoder_snapshot();
    cmd_pkg::spi_word_u reply;
    int i;
    for (i = 0; i < 10; i++)
      quad_move(1'b1);
    for (i = 0; i < 3; i++)
      quad_move(1'b0);
    run_move(1'b1, 8, QUARTER, 0, reply);
    check_count("encoder snapshot", reply.data.value, enc_expect);
    {ENC_A, ENC_B} = ~{ENC_A, ENC_B};  // Both lines at once
    i = 0;
    while (!ENC_FAULT && i < 8) begin
      wait_cycles(1);
      i++;
    end
    check_bit("ENC_FAULT", ENC_FAULT, 1'b1);
  endtask

  task test_queue_backpressure();
    cmd_pkg::spi_word_u reply;
    int i, dur, n, exp_steps, base_steps, base_done;
    base_steps = step_count;
    base_done  = done_count;
    exp_steps  = 0;
    set_tick_div(SLOW_DIV);
    for (i = 0; i <= MOVE_DEPTH; i++) begin
      check_bit("BUFFER_DTR", BUFFER_DTR, 1'b1);
      dur = (i == 0) ? LONG_TICKS : 4;
      dda_model(dur, QUARTER, 0, n);
      exp_steps += n;
      send_move(1'b1, dur, QUARTER, 0, reply);
    end
    check_bit("BUFFER_DTR", BUFFER_DTR, 1'b0);
    send_move(1'b0, 4, QUARTER, 0, reply);  // Dropped, queue full
    wait_toggles(base_done + MOVE_DEPTH + 1);
    wait_cycles(DROP_WAIT_CYC);
    check_count("move_done_toggles", done_count - base_done, MOVE_DEPTH + 1);
    check_count("step_count", step_count - base_steps, exp_steps);
  endtask

  task test_halt_flush();
    cmd_pkg::spi_word_u reply;
    int i, base_steps, base_done;
    for (i = 0; i < 3; i++)
      send_move(1'b1, HALT_TICKS, EIGHTH, 0, reply);
    HALT = 1'b0;
    wait_cycles(2);
    HALT = 1'b1;
    model_acc  = 0;  // Halt clears the accumulator
    base_steps = step_count;
    base_done  = done_count;
    wait_cycles(QUIET_CYC);
    check_count("step_count after halt", step_count - base_steps, 0);
    check_count("move_done_toggles after halt", done_count - base_done, 0);
    check_bit("BUFFER_DTR", BUFFER_DTR, 1'b1);
    set_tick_div(3);
    run_move(1'b1, 32, QUARTER, 0, reply);
  endtask

  initial begin
    resetn = 1'b0;
    SCK    = 1'b0;
    CS     = 1'b1;
    COPI   = 1'b0;
    ENC_A  = 1'b0;
    ENC_B  = 1'b0;
    HALT   = 1'b1;
    repeat (16) @(posedge CLK);
    #1 resetn = 1'b1;
    wait_cycles(2);
    check_reset_state();
    test_version_enable();
    test_constant_move();
    test_accel_move();
    test_encoder_snapshot();
    test_queue_backpressure();
    test_halt_flush();
    $display("Errors: %0d check failures, %0d assertion failures",
             errors, DUT.u_props.assert_fails);
    if (errors == 0 && DUT.u_props.assert_fails == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: tb.f
logic/cmd_pkg.sv
logic/motion_pkg.sv
logic/move_if.sv
logic/spi_word_rx.sv
logic/cmd_decoder.sv
logic/move_queue.sv
logic/dda_stepper.sv
logic/quad_enc.sv
logic/stepper_top.sv
sim/stepper_top_properties.sv
sim/tb_stepper_top.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_stepper_top \
  -f tb.f --Mdir obj_dir -o tb_sim > build.log 2>&1 &&
  ./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1 ||
  { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log && echo "PASS" ||
  { echo "FAIL, see sim.log"; exit 1; }
